// ==== hw/video_defs.svh ====
// Raster size, tile geometry and address width macros for the video subsystem
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Raster, 48x32 visible inside 64x40
`define H_TOTAL   64
`define H_ACTIVE  48
`define V_TOTAL   40
`define V_ACTIVE  32

// Six visible tiles plus one for fine scroll
`define TILE_COLS 7

// Line buffer address width
`define LBUF_AW   6

// Graphics ROM address: row[7:3], tile, row[2:0]
`define ROM_AW    13

`endif

// ==== hw/video_pkg.sv ====
// Palette entry, CPU write word, scroll registers, write ports and RGB types
`include "video_defs.svh"

package video_pkg;

    // Brightness in the top nibble
    typedef struct packed {
        logic [3:0] bright;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pal_entry_t;

    // CPU data seen as a palette colour or as a plain register value
    typedef union packed {
        pal_entry_t  pal;
        logic [15:0] raw;
    } cpu_word_u;

    typedef struct packed {
        logic [7:0] hpos;
        logic [7:0] vpos;
        logic       layer_en;
    } scroll_regs_t;

    typedef struct packed {
        logic       wr;
        logic [3:0] idx;
        pal_entry_t col;
    } pal_wr_t;

    typedef struct packed {
        logic                we;
        logic [`LBUF_AW-1:0] addr;
        logic [3:0]          pix;
    } lbuf_wr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

// ==== hw/video_timing.sv ====
// Raster timing generator with pixel and line counters, blanking, sync and line start
`timescale 1ns/1ns
`include "video_defs.svh"

module video_timing (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [5:0] hdump,
    output logic [5:0] vdump,
    output logic       line_start,
    output logic       HB,
    output logic       VB,
    output logic       HS,
    output logic       VS
);

// Sync pulses sit a little after the active area
localparam int HS_START = `H_ACTIVE + 4;
localparam int HS_END   = HS_START + 4;
localparam int VS_START = `V_ACTIVE + 2;
localparam int VS_END   = VS_START + 2;

logic h_last;
logic v_last;

assign h_last = hdump == 6'(`H_TOTAL - 1);
assign v_last = vdump == 6'(`V_TOTAL - 1);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        hdump      <= '0;
        vdump      <= '0;
        line_start <= 1'b0;
    end else begin
        // High while hdump is 0, once vdump already holds the new line
        line_start <= pxl_cen && h_last;
        if (pxl_cen) begin
            hdump <= h_last ? 6'd0 : hdump + 6'd1;
            if (h_last) begin
                vdump <= v_last ? 6'd0 : vdump + 6'd1;
            end
        end
    end
end

assign HB = hdump >= 6'(`H_ACTIVE);
assign VB = vdump >= 6'(`V_ACTIVE);
assign HS = (hdump >= 6'(HS_START)) && (hdump < 6'(HS_END));
assign VS = (vdump >= 6'(VS_START)) && (vdump < 6'(VS_END));

endmodule

// ==== hw/video_mmr.sv ====
// CPU register block for scroll, layer control and palette write strobes
`timescale 1ns/1ns

module video_mmr import video_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cpu_cs,
    input  logic [4:0]   cpu_addr,
    input  cpu_word_u    cpu_din,
    output scroll_regs_t regs,
    output pal_wr_t      pal_wr
);

localparam logic [4:0] ADDR_HPOS = 5'd0;
localparam logic [4:0] ADDR_VPOS = 5'd1;
localparam logic [4:0] ADDR_CTRL = 5'd2;

logic pal_hit;

// Upper half of the map is the palette
assign pal_hit = cpu_cs && cpu_addr[4];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        regs   <= '0;
        pal_wr <= '0;
    end else begin
        pal_wr.wr  <= pal_hit;
        pal_wr.idx <= cpu_addr[3:0];
        pal_wr.col <= cpu_din.pal;
        if (cpu_cs) begin
            case (cpu_addr)
                ADDR_HPOS: regs.hpos     <= cpu_din.raw[7:0];
                ADDR_VPOS: regs.vpos     <= cpu_din.raw[7:0];
                ADDR_CTRL: regs.layer_en <= cpu_din.raw[0];
                default: begin
                    // Palette or unmapped
                end
            endcase
        end
    end
end

endmodule

// ==== hw/tile_fetch.sv ====
// Tile row fetcher that reads the graphics ROM and fills the line buffer
`timescale 1ns/1ns
`include "video_defs.svh"

module tile_fetch import video_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               line_start,
    input  logic [5:0]         vdump,
    input  scroll_regs_t       regs,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    output logic [`ROM_AW-1:0] rom_addr,
    output logic               rom_cs,
    output lbuf_wr_t           lbuf_wr
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_UNPACK
} state_t;

state_t      state;
logic [4:0]  coarse;
logic [7:0]  row;
logic [2:0]  col;
logic [2:0]  nib;
logic [31:0] tile_row;
logic [5:0]  vrender;
logic [4:0]  tile;

// Line to be shown next
assign vrender = (vdump == 6'(`V_TOTAL - 1)) ? 6'd0 : vdump + 6'd1;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state  <= ST_IDLE;
        coarse <= '0;
        row    <= '0;
        col    <= '0;
        nib    <= '0;
    end else if (line_start) begin
        // Restart even if the previous line did not finish
        coarse <= regs.hpos[7:3];
        row    <= {2'b00, vrender} + regs.vpos;
        col    <= '0;
        state  <= (vrender < 6'(`V_ACTIVE)) ? ST_REQ : ST_IDLE;
    end else begin
        case (state)
            ST_REQ: begin
                if (rom_ok) begin
                    nib   <= '0;
                    state <= ST_UNPACK;
                end
            end
            ST_UNPACK: begin
                nib <= nib + 3'd1;
                if (nib == 3'd7) begin
                    if (col == 3'(`TILE_COLS - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        col   <= col + 3'd1;
                        state <= ST_REQ;
                    end
                end
            end
            default: begin
                state <= ST_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (rom_cs && rom_ok) begin
        tile_row <= rom_data;
    end
end

// Tile index wraps every 32 columns
assign tile     = coarse + {2'b00, col};
assign rom_cs   = state == ST_REQ;
assign rom_addr = {row[7:3], tile, row[2:0]};

// Nibble k lands at buffer address 8c+k
always_comb begin
    lbuf_wr.we   = (state == ST_UNPACK) && !line_start;
    lbuf_wr.addr = {col, nib};
    lbuf_wr.pix  = tile_row[{nib, 2'b00} +: 4];
end

endmodule

// ==== hw/line_buffer.sv ====
// Ping-pong line buffer with bank swap at each line start
`timescale 1ns/1ns
`include "video_defs.svh"

module line_buffer import video_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                line_start,
    input  lbuf_wr_t            wr,
    input  logic [`LBUF_AW-1:0] rd_addr,
    output logic [3:0]          rd_pix
);

localparam int DEPTH = 1 << `LBUF_AW;

logic [3:0] mem [0:1][0:DEPTH-1];
// Write bank, the read side uses the other one
logic       bank;
logic       rd_bank;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        bank <= 1'b0;
    end else if (line_start) begin
        bank <= ~bank;
    end
end

// Swap clock already reads from the bank that was just filled
assign rd_bank = line_start ? bank : ~bank;

always_ff @(posedge clk) begin
    if (wr.we) begin
        mem[bank][wr.addr] <= wr.pix;
    end
    rd_pix <= mem[rd_bank][rd_addr];
end

endmodule

// ==== hw/colmix.sv ====
// Colour mixer with fine scroll, palette RAM, brightness scaling and blanking
`timescale 1ns/1ns
`include "video_defs.svh"

module colmix import video_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  logic [5:0]          hdump,
    input  logic                HB,
    input  logic                VB,
    input  scroll_regs_t        regs,
    input  pal_wr_t             pal_wr,
    input  logic [3:0]          rd_pix,
    output logic [`LBUF_AW-1:0] rd_addr,
    output rgb_t                rgb,
    output logic                lhbl,
    output logic                lvbl
);

pal_entry_t palette [0:15];
logic [3:0] idx;
pal_entry_t col;
rgb_t       scaled;

// 4-bit colour to 8 bits, times (bright+1)/16
function automatic logic [7:0] scale(input logic [3:0] chan, input logic [3:0] bright);
    logic [12:0] prod;
    prod = {5'd0, chan, chan} * {8'd0, {1'b0, bright} + 5'd1};
    return prod[11:4];
endfunction

// Fine scroll offsets into the extra tile
assign rd_addr = hdump + {3'd0, regs.hpos[2:0]};
assign idx     = regs.layer_en ? rd_pix : 4'd0;
assign col     = palette[idx];

always_comb begin
    scaled.red   = scale(col.red, col.bright);
    scaled.green = scale(col.green, col.bright);
    scaled.blue  = scale(col.blue, col.bright);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < 16; i++) begin
            palette[i] <= '0;
        end
    end else if (pal_wr.wr) begin
        palette[pal_wr.idx] <= pal_wr.col;
    end
end

// Outputs lag hdump by one pixel
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rgb  <= '0;
        lhbl <= 1'b0;
        lvbl <= 1'b0;
    end else if (pxl_cen) begin
        lhbl <= ~HB;
        lvbl <= ~VB;
        rgb  <= (HB || VB) ? '0 : scaled;
    end
end

endmodule

// ==== hw/video_top.sv ====
// Video subsystem top level with timing, registers, fetcher, line buffer and mixer
`timescale 1ns/1ns
`include "video_defs.svh"

module video_top import video_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    // CPU write port
    input  logic               cpu_cs,
    input  logic [4:0]         cpu_addr,
    input  cpu_word_u          cpu_din,
    // Raster
    output logic [5:0]         hdump,
    output logic [5:0]         vdump,
    output logic               HS,
    output logic               VS,
    // Graphics ROM
    output logic [`ROM_AW-1:0] rom_addr,
    output logic               rom_cs,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    // Video out
    output rgb_t               rgb,
    output logic               lhbl,
    output logic               lvbl
);

logic                line_start;
logic                HB;
logic                VB;
scroll_regs_t        regs;
pal_wr_t             pal_wr;
lbuf_wr_t            lbuf_wr;
logic [`LBUF_AW-1:0] rd_addr;
logic [3:0]          rd_pix;

video_timing u_timing (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .hdump      ( hdump      ),
    .vdump      ( vdump      ),
    .line_start ( line_start ),
    .HB         ( HB         ),
    .VB         ( VB         ),
    .HS         ( HS         ),
    .VS         ( VS         )
);

video_mmr u_mmr (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .cpu_cs     ( cpu_cs     ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_din    ( cpu_din    ),
    .regs       ( regs       ),
    .pal_wr     ( pal_wr     )
);

tile_fetch u_fetch (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .line_start ( line_start ),
    .vdump      ( vdump      ),
    .regs       ( regs       ),
    .rom_data   ( rom_data   ),
    .rom_ok     ( rom_ok     ),
    .rom_addr   ( rom_addr   ),
    .rom_cs     ( rom_cs     ),
    .lbuf_wr    ( lbuf_wr    )
);

line_buffer u_lbuf (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .line_start ( line_start ),
    .wr         ( lbuf_wr    ),
    .rd_addr    ( rd_addr    ),
    .rd_pix     ( rd_pix     )
);

colmix u_colmix (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .hdump      ( hdump      ),
    .HB         ( HB         ),
    .VB         ( VB         ),
    .regs       ( regs       ),
    .pal_wr     ( pal_wr     ),
    .rd_pix     ( rd_pix     ),
    .rd_addr    ( rd_addr    ),
    .rgb        ( rgb        ),
    .lhbl       ( lhbl       ),
    .lvbl       ( lvbl       )
);

endmodule

// ==== dv/video_tb.sv ====
// Testbench for the video subsystem with clock, ROM model, stimulus table and compare tasks
`timescale 1ns/1ns
`include "video_defs.svh"

module video_tb import video_pkg::*; ();

typedef struct packed {
    logic [7:0]  hpos;
    logic [7:0]  vpos;
    logic [15:0] ctrl;
    logic        new_pal;
} stim_t;

localparam int NUM_STIM    = 8;
localparam int FRAME_CLKS  = `H_TOTAL * `V_TOTAL * 2;

logic         clk;
logic         rst_n;
logic         pxl_cen  = 1'b0;
logic         cpu_cs;
logic [4:0]   cpu_addr;
cpu_word_u    cpu_din;
logic [5:0]   hdump;
logic [5:0]   vdump;
logic         HS;
logic         VS;
logic [12:0]  rom_addr;
logic         rom_cs;
logic [31:0]  rom_data = '0;
logic         rom_ok   = 1'b0;
rgb_t         rgb;
logic         lhbl;
logic         lvbl;

int           rom_wait = 0;
scroll_regs_t regs_model;
pal_entry_t   pal_model [0:15];

// hpos, vpos, control word, fresh random palette
stim_t stim_table [NUM_STIM] = '{
    '{8'h00, 8'h00, 16'h0001, 1'b1},
    '{8'h08, 8'h00, 16'h0001, 1'b0},
    '{8'h03, 8'h05, 16'h0001, 1'b0},
    '{8'h2d, 8'hf7, 16'h0001, 1'b0},
    '{8'hff, 8'h81, 16'hfff1, 1'b1},
    '{8'h13, 8'h40, 16'h0000, 1'b1},
    '{8'h13, 8'h40, 16'h8001, 1'b0},
    '{8'h13, 8'h40, 16'h0001, 1'b1}
};

video_top video_top_i (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .cpu_cs   ( cpu_cs   ),
    .cpu_addr ( cpu_addr ),
    .cpu_din  ( cpu_din  ),
    .hdump    ( hdump    ),
    .vdump    ( vdump    ),
    .HS       ( HS       ),
    .VS       ( VS       ),
    .rom_addr ( rom_addr ),
    .rom_cs   ( rom_cs   ),
    .rom_data ( rom_data ),
    .rom_ok   ( rom_ok   ),
    .rgb      ( rgb      ),
    .lhbl     ( lhbl     ),
    .lvbl     ( lvbl     )
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// Pixel enable on every second clock
always @(posedge clk) begin
    pxl_cen <= ~pxl_cen;
end

// Graphics ROM with 1 to 4 clocks of latency
always @(posedge clk) begin
    if (!rst_n) begin
        rom_ok   <= 1'b0;
        rom_wait <= 0;
    end else if (rom_ok) begin
        rom_ok <= 1'b0;
    end else if (rom_cs) begin
        if (rom_wait == 0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(rom_addr);
        end else begin
            rom_wait <= rom_wait - 1;
        end
    end else begin
        rom_wait <= int'($urandom_range(3, 0));
    end
end

// Nibble k scrambles the address XOR k
function automatic logic [31:0] rom_word(input logic [12:0] addr);
    logic [31:0] word;
    logic [15:0] mix;
    word = '0;
    for (int k = 0; k < 8; k++) begin
        mix = ({3'd0, addr} ^ 16'(k)) * 16'h9e37;
        word[4*k +: 4] = mix[15:12] ^ mix[7:4];
    end
    return word;
endfunction

function automatic logic [7:0] scale_chan(input logic [3:0] c, input logic [3:0] b);
    int v;
    v = (int'(c) * 17 * (int'(b) + 1)) / 16;
    return 8'(v);
endfunction

// Colour of pixel (h, v) from scroll, ROM layout and palette
function automatic rgb_t expected_rgb(input int h, input int v);
    int          a;
    int          y;
    int          t;
    logic [31:0] word;
    logic [3:0]  pix;
    pal_entry_t  e;
    rgb_t        res;
    res = '0;
    if (h < `H_ACTIVE && v < `V_ACTIVE) begin
        a    = h + int'(regs_model.hpos) % 8;
        y    = (v + int'(regs_model.vpos)) % 256;
        t    = (int'(regs_model.hpos) / 8 + a / 8) % 32;
        word = rom_word(13'((y / 8) * 256 + t * 8 + y % 8));
        pix  = regs_model.layer_en ? word[4*(a%8) +: 4] : 4'd0;
        e    = pal_model[pix];
        res.red   = scale_chan(e.red, e.bright);
        res.green = scale_chan(e.green, e.bright);
        res.blue  = scale_chan(e.blue, e.bright);
    end
    return res;
endfunction

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
endtask

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                            $time, name, got, exp));
    end
endtask

task automatic check_blank(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                            $time, name, got, exp));
    end
endtask

task automatic check_count(input string name, input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                            $time, name, got, exp));
    end
endtask

task automatic cpu_write(input logic [4:0] addr, input logic [15:0] data);
    @(posedge clk);
    cpu_cs      <= 1'b1;
    cpu_addr    <= addr;
    cpu_din.raw <= data;
    @(posedge clk);
    cpu_cs <= 1'b0;
endtask

task automatic apply_entry(input stim_t s);
    cpu_write(5'd0, {8'($urandom()), s.hpos});
    cpu_write(5'd1, {8'($urandom()), s.vpos});
    cpu_write(5'd2, s.ctrl);
    regs_model.hpos     = s.hpos;
    regs_model.vpos     = s.vpos;
    regs_model.layer_en = s.ctrl[0];
    // Unmapped addresses, no effect expected
    cpu_write(5'd3, 16'($urandom()));
    cpu_write(5'd15, 16'($urandom()));
    if (s.new_pal) begin
        for (int j = 0; j < 16; j++) begin
            pal_model[j] = pal_entry_t'(16'($urandom()));
            cpu_write(5'(16 + j), pal_model[j]);
        end
    end
endtask

task automatic wait_line(input int target);
    int waited;
    waited = 0;
    while (vdump != 6'(target)) begin
        @(negedge clk);
        waited++;
        if (waited > 2 * FRAME_CLKS) begin
            abort_run($sformatf("Timed out waiting for line %0d", target));
        end
    end
endtask

// Compares one pixel per hdump step against the previous position
task automatic scan_frame(input logic rom_quiet);
    int         count;
    int         waited;
    logic [5:0] ph;
    logic [5:0] pv;
    logic [5:0] eh;
    logic [5:0] ev;
    logic       hs_seen;
    logic       vs_seen;
    ph      = hdump;
    pv      = vdump;
    count   = 0;
    waited  = 0;
    hs_seen = 1'b0;
    vs_seen = 1'b0;
    while (count < `H_TOTAL * `V_TOTAL) begin
        @(negedge clk);
        waited++;
        if (waited > FRAME_CLKS + 64) begin
            abort_run("Timed out while the raster counters stopped advancing");
        end
        if (rom_quiet && vdump == 6'd0) begin
            check_blank("rom_cs", rom_cs, 1'b0);
        end
        if (hdump != ph || vdump != pv) begin
            check_rgb($sformatf("rgb(%0d,%0d)", ph, pv), rgb,
                      expected_rgb(int'(ph), int'(pv)));
            check_blank("lhbl", lhbl, int'(ph) < `H_ACTIVE);
            check_blank("lvbl", lvbl, int'(pv) < `V_ACTIVE);
            // Raster steps one pixel, wrapping into the next line and frame
            eh = (ph == 6'(`H_TOTAL - 1)) ? 6'd0 : ph + 6'd1;
            ev = pv;
            if (eh == 6'd0) begin
                ev = (pv == 6'(`V_TOTAL - 1)) ? 6'd0 : pv + 6'd1;
                if (!hs_seen) begin
                    abort_run($sformatf("No HS pulse during line %0d", pv));
                end
                hs_seen = 1'b0;
            end
            check_count("hdump", hdump, eh);
            check_count("vdump", vdump, ev);
            // Sync pulses only inside blanking
            if (eh < 6'(`H_ACTIVE)) begin
                check_blank("HS", HS, 1'b0);
            end
            if (ev < 6'(`V_ACTIVE)) begin
                check_blank("VS", VS, 1'b0);
            end
            hs_seen = hs_seen | HS;
            vs_seen = vs_seen | VS;
            ph = eh;
            pv = ev;
            count++;
        end
    end
    if (!vs_seen) begin
        abort_run("No VS pulse during the frame");
    end
endtask

initial begin
    void'($urandom(32'haaa6));
    rst_n      = 1'b0;
    cpu_cs     = 1'b0;
    cpu_addr   = '0;
    cpu_din    = '0;
    regs_model = '0;
    for (int j = 0; j < 16; j++) begin
        pal_model[j] = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Black frame from reset, fetcher quiet on line 0
    @(negedge clk);
    scan_frame(1'b1);
    for (int i = 0; i < NUM_STIM; i++) begin
        apply_entry(stim_table[i]);
        wait_line(`V_TOTAL - 1);
        wait_line(0);
        scan_frame(1'b0);
    end
    $display("All tests passed");
    $finish;
end

endmodule

// ==== src.f ====
+incdir+hw
hw/video_pkg.sv
hw/video_timing.sv
hw/video_mmr.sv
hw/tile_fetch.sv
hw/line_buffer.sv
hw/colmix.sv
hw/video_top.sv
dv/video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Some tests failed"

verilator --binary --timing --top-module video_tb -f src.f -o video_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without errors"
exit 0
